//--- bench/tb_bpu_model.svh
/*
 * Reference model of the branch prediction unit
 * Counters, global history, BTB rows and the fetch PC rules
 */

`ifndef TB_BPU_MODEL_SVH
`define TB_BPU_MODEL_SVH

  // Same values as the DUT defaults
  localparam int unsigned M_HLEN     = 4;
  localparam int unsigned M_BTB_BITS = 3;
  localparam logic [31:0] M_BOOT_PC  = 32'h0000_0080;

  // Tag starts right above the BTB row bits
  localparam int unsigned M_TAG_LO = bpu_pkg::OFFSET + M_BTB_BITS;

  // Counters as 0..3, SNT up to ST
  logic [1:0]        m_ctr [1 << M_HLEN];
  logic [M_HLEN-1:0] m_ghr;
  logic              m_valid [1 << M_BTB_BITS];
  logic [31:0]       m_tag [1 << M_BTB_BITS];
  logic [31:0]       m_target [1 << M_BTB_BITS];
  logic [31:0]       m_pc;

  // XOR of history and word address bits
  function automatic logic [M_HLEN-1:0] ctr_index(input logic [31:0] pc);
    logic [31:0] h;
    h = (pc >> bpu_pkg::OFFSET) ^ {{(32-M_HLEN){1'b0}}, m_ghr};
    return h[M_HLEN-1:0];
  endfunction

  function automatic logic [M_BTB_BITS-1:0] btb_row(input logic [31:0] pc);
    return pc[bpu_pkg::OFFSET +: M_BTB_BITS];
  endfunction

  function automatic logic btb_hits(input logic [31:0] pc);
    return m_valid[btb_row(pc)] && (m_tag[btb_row(pc)] == (pc >> M_TAG_LO));
  endfunction

  // Taken needs a taken counter and a BTB hit
  function automatic logic model_taken();
    return m_ctr[ctr_index(m_pc)][1] && btb_hits(m_pc);
  endfunction

  function automatic logic [31:0] model_target();
    return m_target[btb_row(m_pc)];
  endfunction

  function automatic void clear_tables();
    m_ghr = '0;
    for (int i = 0; i < (1 << M_HLEN); i++) begin
      m_ctr[i] = 2'd0;
    end
    for (int i = 0; i < (1 << M_BTB_BITS); i++) begin
      m_valid[i] = 1'b0;
    end
  endfunction

  function automatic void model_reset();
    clear_tables();
    m_pc = M_BOOT_PC;
  endfunction

  // One rising edge with the inputs seen at that edge
  function automatic void model_edge(input logic fl, input logic fen,
                                     input bpu_pkg::resolution_t r);
    logic [31:0]           nxt;
    logic [M_HLEN-1:0]     ci;
    logic [M_BTB_BITS-1:0] bi;
    // PC choice uses the tables before this edge
    nxt = m_pc;
    if (r.valid && r.mispredict) begin
      nxt = r.taken ? r.target : r.pc + 32'd4;
    end else if (fen) begin
      nxt = model_taken() ? model_target() : m_pc + 32'd4;
    end
    if (fl) begin
      clear_tables();
    end else if (r.valid) begin
      // Index taken with the history before the shift
      ci = ctr_index(r.pc);
      if (r.taken && m_ctr[ci] != 2'd3) m_ctr[ci] = m_ctr[ci] + 2'd1;
      if (!r.taken && m_ctr[ci] != 2'd0) m_ctr[ci] = m_ctr[ci] - 2'd1;
      m_ghr = {m_ghr[M_HLEN-2:0], r.taken};
      if (r.taken) begin
        bi = btb_row(r.pc);
        m_valid[bi]  = 1'b1;
        m_tag[bi]    = r.pc >> M_TAG_LO;
        m_target[bi] = r.target;
      end
    end
    m_pc = nxt;
  endfunction

`endif

//--- bench/tb_bpu.sv
/*
 * Testbench for the branch prediction unit
 * Clock, reset, stimulus tasks, fetch checks against the model,
 * per-test report and cycle timeout
 */

`timescale 1ns/10ps

module tb_bpu;

  // Longest run of the tests is about 330 cycles
  // Limit leaves a wide margin
  localparam int unsigned TIMEOUT_CYCLES = 1000;

  logic                 clk;
  logic                 rst_n;
  logic                 flush;
  logic                 fetch_en;
  bpu_pkg::resolution_t res;
  bpu_pkg::fetch_t      fetch;

  int unsigned cycles;
  int unsigned err_cnt;
  int unsigned test_err;
  int unsigned pass_cnt;
  int unsigned fail_cnt;

  `include "tb_bpu_model.svh"

  bpu_top i_bpu_top (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .flush_i    (flush),
    .fetch_en_i (fetch_en),
    .res_i      (res),
    .fetch_o    (fetch)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // --------------------------------------------------
  // Model tracking and checks
  // --------------------------------------------------

  // Inputs are driven with NBAs, so old values are seen here
  always @(posedge clk) begin
    if (!rst_n) model_reset();
    else model_edge(flush, fetch_en, res);
  end

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    $display("[ERROR] %s got %h expected %h", name, got, exp);
    err_cnt++;
  endtask

  // Compare at the falling edge where fetch_o is settled
  always @(negedge clk) begin
    if (rst_n) begin
      assert (fetch.pc == m_pc)
        else report_value("fetch_o.pc", fetch.pc, m_pc);
      assert (fetch.pred_taken == model_taken())
        else report_value("fetch_o.pred_taken", fetch.pred_taken, model_taken());
      // Target only means something on a taken prediction
      if (model_taken()) begin
        assert (fetch.pred_target == model_target())
          else report_value("fetch_o.pred_target", fetch.pred_target, model_target());
      end
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  // One-cycle resolution strobe, returns at the edge that consumes it
  task automatic resolve(input logic [31:0] pc, input logic taken,
                         input logic [31:0] tgt, input logic mis);
    @(posedge clk);
    res <= {1'b1, pc, taken, tgt, mis};
    @(posedge clk);
    res <= '0;
  endtask

  // Fetch record against a known PC and direction
  task automatic expect_fetch(input logic [31:0] pc, input logic taken);
    @(negedge clk);
    assert (fetch.pc == pc) else report_value("fetch_o.pc", fetch.pc, pc);
    assert (fetch.pred_taken == taken)
      else report_value("fetch_o.pred_taken", fetch.pred_taken, taken);
  endtask

  task automatic finish_test(input string name);
    if (err_cnt == test_err) begin
      pass_cnt++;
      $display("Test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("Test %s: %0d errors", name, err_cnt - test_err);
    end
    test_err = err_cnt;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    logic [31:0] br_pc;
    logic [31:0] br_target;
    logic [31:0] alias_pc;
    cycles   = 0;
    err_cnt  = 0;
    test_err = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    rst_n    = 1'b0;
    flush    = 1'b0;
    fetch_en = 1'b0;
    res      = '0;
    br_pc     = M_BOOT_PC + 32'd24;
    br_target = 32'h0000_0400;
    // Same BTB row as br_pc, other tag
    alias_pc  = br_pc + 32'h0000_1000;
    void'($urandom(78732));
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Boot address, six steps, then hold
    expect_fetch(M_BOOT_PC, 1'b0);
    @(posedge clk);
    fetch_en <= 1'b1;
    repeat (6) @(posedge clk);
    fetch_en <= 1'b0;
    repeat (3) @(posedge clk);
    expect_fetch(br_pc, 1'b0);
    finish_test("reset and sequential fetch");

    // History fills with ones, then two updates hit one counter
    repeat (5) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b0);
    resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b1);
    // Up to strongly taken and one more update held there
    repeat (2) resolve(br_pc, 1'b1, br_target, 1'b0);
    // Not-taken steps back one state
    // Four takens refill the history on other counters
    resolve(br_pc, 1'b0, br_target, 1'b0);
    repeat (4) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b1);
    resolve(br_pc, 1'b0, br_target, 1'b0);
    repeat (4) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b0);
    finish_test("counter saturation");

    repeat (6) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b1);
    @(posedge clk);
    fetch_en <= 1'b1;
    @(posedge clk);
    fetch_en <= 1'b0;
    expect_fetch(br_target, 1'b0);
    // Taken redirect onto the alias keeps the history at all ones
    // so the alias reads a taken counter and only the tag refuses
    resolve(br_target, 1'b1, alias_pc, 1'b1);
    expect_fetch(alias_pc, 1'b0);
    finish_test("btb target and tags");

    // Same PC looked up under many histories
    resolve(br_pc - 32'd4, 1'b0, 32'h0, 1'b1);
    for (int i = 0; i < 48; i++) begin
      resolve(br_pc, $urandom % 2, br_target, 1'b0);
      repeat ($urandom % 3) @(posedge clk);
    end
    finish_test("history hashing");

    resolve(32'h0000_0200, 1'b1, 32'h0000_0300, 1'b1);
    expect_fetch(32'h0000_0300, 1'b0);
    resolve(32'h0000_0500, 1'b0, 32'h0, 1'b1);
    expect_fetch(32'h0000_0504, 1'b0);
    resolve(br_pc - 32'd4, 1'b0, 32'h0, 1'b1);
    repeat (6) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b1);
    // Redirect against a live taken prediction
    @(posedge clk);
    fetch_en <= 1'b1;
    res      <= {1'b1, 32'h0000_0200, 1'b1, 32'h0000_0600, 1'b1};
    @(posedge clk);
    fetch_en <= 1'b0;
    res      <= '0;
    expect_fetch(32'h0000_0600, 1'b0);
    finish_test("mispredict redirect");

    resolve(br_pc - 32'd4, 1'b0, 32'h0, 1'b1);
    repeat (6) resolve(br_pc, 1'b1, br_target, 1'b0);
    expect_fetch(br_pc, 1'b1);
    @(posedge clk);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    expect_fetch(br_pc, 1'b0);
    @(posedge clk);
    fetch_en <= 1'b1;
    repeat (3) @(posedge clk);
    fetch_en <= 1'b0;
    expect_fetch(br_pc + 32'd12, 1'b0);
    resolve(br_pc - 32'd4, 1'b0, 32'h0, 1'b1);
    expect_fetch(br_pc, 1'b0);
    // Counter read by br_pc trained through a branch in another BTB row
    repeat (6) resolve(br_pc + 32'd4, 1'b1, br_target, 1'b0);
    resolve(br_pc, 1'b0, br_target, 1'b0);
    // Direction is taken now, the flushed BTB row still misses
    expect_fetch(br_pc, 1'b0);
    finish_test("flush");

    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+bench
hw/bpu_pkg.sv
hw/gshare.sv
hw/btb.sv
hw/pc_gen.sv
hw/bpu_top.sv
bench/tb_bpu.sv

//--- hw/bpu_pkg.sv
/*
 * Shared definitions for the branch prediction unit
 * PC width, word alignment offset, branch resolution record,
 * BTB entry layout and the fetch record sent out of the unit
 */

package bpu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------

  // PC and branch target width
  localparam int unsigned XLEN = 32;

  // Low PC bits skipped by every table index
  // Instructions are always word aligned
  localparam int unsigned OFFSET = 2;

  // --------------------------------------------------
  // Branch resolution from the execute stage
  // --------------------------------------------------

  // One-cycle strobe, consumed in the cycle it is present
  typedef struct packed {
    logic            valid;
    // Address of the resolved branch
    logic [XLEN-1:0] pc;
    // Actual direction
    logic            taken;
    // Destination when taken
    logic [XLEN-1:0] target;
    // Fetch went the wrong way, redirect the PC
    logic            mispredict;
  } resolution_t;

  // --------------------------------------------------
  // BTB entry
  // --------------------------------------------------

  // Tag holds PC bits above OFFSET
  // The BTB compares only the slice above its index bits
  typedef struct packed {
    logic                   valid;
    logic [XLEN-OFFSET-1:0] tag;
    logic [XLEN-1:0]        target;
  } btb_entry_t;

  // --------------------------------------------------
  // Fetch record towards the instruction fetch
  // --------------------------------------------------

  typedef struct packed {
    // Current fetch address
    logic [XLEN-1:0] pc;
    // Direction and target both agree on a taken branch
    logic            pred_taken;
    // Predicted next fetch address when taken
    logic [XLEN-1:0] pred_target;
  } fetch_t;

endpackage

//--- hw/bpu_top.sv
/*
 * Branch prediction unit top level
 * PC generator, gshare direction predictor and BTB
 */

`timescale 1ns/10ps

module bpu_top #(
  parameter int unsigned              HLEN     = 4,
  parameter int unsigned              BTB_BITS = 3,
  parameter logic [bpu_pkg::XLEN-1:0] BOOT_PC  = 32'h0000_0080
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 flush_i,
  input  logic                 fetch_en_i,
  input  bpu_pkg::resolution_t res_i,
  output bpu_pkg::fetch_t      fetch_o
);

  // Lookup address and predictor answers
  logic [bpu_pkg::XLEN-1:0] pc;
  logic                     dir_taken;
  logic                     btb_hit;
  logic [bpu_pkg::XLEN-1:0] btb_target;

  // --------------------------------------------------
  // Fetch PC
  // --------------------------------------------------

  pc_gen #(
    .BOOT_PC (BOOT_PC)
  ) i_pc_gen (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .fetch_en_i   (fetch_en_i),
    .res_i        (res_i),
    .dir_taken_i  (dir_taken),
    .btb_hit_i    (btb_hit),
    .btb_target_i (btb_target),
    .pc_o         (pc),
    .fetch_o      (fetch_o)
  );

  // --------------------------------------------------
  // Predictors
  // --------------------------------------------------

  gshare #(
    .HLEN (HLEN)
  ) i_gshare (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .flush_i (flush_i),
    .pc_i    (pc),
    .res_i   (res_i),
    .taken_o (dir_taken)
  );

  btb #(
    .BTB_BITS (BTB_BITS)
  ) i_btb (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .flush_i  (flush_i),
    .pc_i     (pc),
    .res_i    (res_i),
    .hit_o    (btb_hit),
    .target_o (btb_target)
  );

endmodule

//--- hw/btb.sv
/*
 * Direct-mapped branch target buffer
 * Valid, tag and target per entry, trained by taken resolutions,
 * combinational lookup from the fetch PC
 */

`timescale 1ns/10ps

module btb #(
  parameter int unsigned BTB_BITS = 3
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic [bpu_pkg::XLEN-1:0]   pc_i,
  input  bpu_pkg::resolution_t       res_i,
  output logic                       hit_o,
  output logic [bpu_pkg::XLEN-1:0]   target_o
);

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------

  localparam int unsigned ROWS = 1 << BTB_BITS;

  // Index sits right above the word offset
  localparam int unsigned IDX_LO = bpu_pkg::OFFSET;
  localparam int unsigned IDX_HI = bpu_pkg::OFFSET + BTB_BITS - 1;

  // Width of the stored tag field
  localparam int unsigned TAG_W = bpu_pkg::XLEN - bpu_pkg::OFFSET;

  // Only the tag bits above the index take part in the compare
  localparam int unsigned CMP_LO = BTB_BITS;

  // --------------------------------------------------
  // Storage and lookup signals
  // --------------------------------------------------

  bpu_pkg::btb_entry_t entry_q [ROWS];
  bpu_pkg::btb_entry_t rd_entry;
  bpu_pkg::btb_entry_t wr_entry;

  logic [BTB_BITS-1:0] rd_idx;
  logic [BTB_BITS-1:0] wr_idx;
  logic                tag_match;

  // --------------------------------------------------
  // Lookup
  // --------------------------------------------------

  assign rd_idx   = pc_i[IDX_HI:IDX_LO];
  assign rd_entry = entry_q[rd_idx];

  // Upper PC bits against the stored tag slice
  assign tag_match = (rd_entry.tag[TAG_W-1:CMP_LO] == pc_i[bpu_pkg::XLEN-1:IDX_HI+1]);

  assign hit_o    = rd_entry.valid & tag_match;
  assign target_o = rd_entry.target;

  // --------------------------------------------------
  // Training
  // --------------------------------------------------

  assign wr_idx = res_i.pc[IDX_HI:IDX_LO];

  // New entry from a resolution
  // Tag carries every PC bit above the offset
  always_comb begin
    wr_entry        = '0;
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = res_i.pc[bpu_pkg::XLEN-1:IDX_LO];
    wr_entry.target = res_i.target;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ROWS; i++) begin
        entry_q[i] <= '0;
      end
    end else if (flush_i) begin
      // Drop all entries, tags and targets stay as they are
      for (int i = 0; i < ROWS; i++) begin
        entry_q[i].valid <= 1'b0;
      end
    end else if (res_i.valid && res_i.taken) begin
      // Direct mapped, so an alias in the same row is replaced
      entry_q[wr_idx] <= wr_entry;
    end
    // Not-taken resolutions leave the row untouched
  end

endmodule

//--- hw/gshare.sv
/*
 * Gshare direction predictor
 * Global history register, pattern table of 2-bit saturating
 * counters, XOR hash of history and PC for read and write
 */

`timescale 1ns/10ps

module gshare #(
  parameter int unsigned HLEN = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic [bpu_pkg::XLEN-1:0]   pc_i,
  input  bpu_pkg::resolution_t       res_i,
  output logic                       taken_o
);

  // --------------------------------------------------
  // Local types and storage
  // --------------------------------------------------

  // Counter states, upper bit gives the direction
  typedef enum logic [1:0] {
    SNT = 2'b00,
    WNT = 2'b01,
    WT  = 2'b10,
    ST  = 2'b11
  } ctr_t;

  // One counter per history/PC hash value
  localparam int unsigned PHT_ROWS = 1 << HLEN;

  ctr_t            pht_q [PHT_ROWS];
  logic [HLEN-1:0] ghr_q;
  logic [HLEN-1:0] rd_idx;
  logic [HLEN-1:0] wr_idx;

  // Saturating step of one counter
  function automatic ctr_t ctr_step(input ctr_t cur, input logic taken);
    ctr_t nxt;
    nxt = cur;
    case (cur)
      SNT: nxt = taken ? WNT : SNT;
      WNT: nxt = taken ? WT  : SNT;
      WT:  nxt = taken ? ST  : WNT;
      ST:  nxt = taken ? ST  : WT;
      default: nxt = SNT;
    endcase
    return nxt;
  endfunction

  // --------------------------------------------------
  // Index hashing
  // --------------------------------------------------

  // Lookup with the fetch PC and the current history
  assign rd_idx = ghr_q ^ pc_i[HLEN+bpu_pkg::OFFSET-1:bpu_pkg::OFFSET];

  // Update uses the history before this cycle's shift
  // so it lands on the counter a lookup of res_i.pc would use
  assign wr_idx = ghr_q ^ res_i.pc[HLEN+bpu_pkg::OFFSET-1:bpu_pkg::OFFSET];

  // --------------------------------------------------
  // Global history register
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ghr_q <= '0;
    end else if (flush_i) begin
      ghr_q <= '0;
    end else if (res_i.valid) begin
      // Newest outcome enters at bit 0
      ghr_q <= {ghr_q[HLEN-2:0], res_i.taken};
    end
  end

  // --------------------------------------------------
  // Pattern history table
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= SNT;
      end
    end else if (flush_i) begin
      // Flush wins over a resolution in the same cycle
      for (int i = 0; i < PHT_ROWS; i++) begin
        pht_q[i] <= SNT;
      end
    end else if (res_i.valid) begin
      pht_q[wr_idx] <= ctr_step(pht_q[wr_idx], res_i.taken);
    end
  end

  // Predict taken in WT and ST
  assign taken_o = pht_q[rd_idx][1];

endmodule

//--- hw/pc_gen.sv
/*
 * Fetch PC generator
 * Fetch PC register, prediction from direction and BTB,
 * next-PC selection with redirect, prediction and sequential step
 */

`timescale 1ns/10ps

module pc_gen #(
  parameter logic [bpu_pkg::XLEN-1:0] BOOT_PC = 32'h0000_0080
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       fetch_en_i,
  input  bpu_pkg::resolution_t       res_i,
  input  logic                       dir_taken_i,
  input  logic                       btb_hit_i,
  input  logic [bpu_pkg::XLEN-1:0]   btb_target_i,
  output logic [bpu_pkg::XLEN-1:0]   pc_o,
  output bpu_pkg::fetch_t            fetch_o
);

  // Uncompressed instructions only
  localparam logic [bpu_pkg::XLEN-1:0] PC_STEP = 4;

  logic [bpu_pkg::XLEN-1:0] pc_q;
  logic [bpu_pkg::XLEN-1:0] pc_d;
  logic [bpu_pkg::XLEN-1:0] seq_pc;
  logic [bpu_pkg::XLEN-1:0] fix_pc;
  logic                     pred_taken;
  logic                     redirect;

  // --------------------------------------------------
  // Prediction
  // --------------------------------------------------

  // Taken needs both a taken counter and a known target
  assign pred_taken = dir_taken_i & btb_hit_i;

  assign seq_pc = pc_q + PC_STEP;

  // --------------------------------------------------
  // Redirect from the execute stage
  // --------------------------------------------------

  assign redirect = res_i.valid & res_i.mispredict;

  // Correct path after a wrong guess
  assign fix_pc = res_i.taken ? res_i.target : (res_i.pc + PC_STEP);

  // --------------------------------------------------
  // Next PC
  // --------------------------------------------------

  always_comb begin
    // Hold by default
    pc_d = pc_q;
    if (redirect) begin
      // Highest priority, fetch enable does not matter
      pc_d = fix_pc;
    end else if (fetch_en_i) begin
      pc_d = pred_taken ? btb_target_i : seq_pc;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------

  // Lookup address for both predictors
  assign pc_o = pc_q;

  // Outward view of the same cycle
  always_comb begin
    fetch_o.pc          = pc_q;
    fetch_o.pred_taken  = pred_taken;
    fetch_o.pred_target = btb_target_i;
  end

endmodule
